// File: src.f
+incdir+include
rtl/ex_pkg.sv
rtl/ex_operand_if.sv
rtl/ex_bypass.sv
rtl/ex_alu.sv
rtl/ex_branch_unit.sv
rtl/ex_lsu.sv
rtl/ex_stage.sv
dv/ex_stage_asserts.sv
dv/tb_ex_stage.sv

// File: Bender.yml
package:
  name: ex_stage

sources:
  - include_dirs:
      - include
    files:
      - rtl/ex_pkg.sv
      - rtl/ex_operand_if.sv
      - rtl/ex_bypass.sv
      - rtl/ex_alu.sv
      - rtl/ex_branch_unit.sv
      - rtl/ex_lsu.sv
      - rtl/ex_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/ex_stage_asserts.sv
      - dv/tb_ex_stage.sv

// File: dv/ex_golden.hex
// ctrl pc insn opa opb imm mdata exp_r exp_npc exp_adr
// ctrl nibbles: stall, check flags, flush, we, size, bubble, bypex, userf
01000000 00000100 00000033 00000005 00000007 00000000 00000000 0000000c 00000000 00000000
01000000 00000104 40000033 00000003 00000008 00000000 00000000 fffffffb 00000000 00000000
01000000 00000108 40005033 80000010 00000004 00000000 00000000 f8000001 00000000 00000000
01000003 0000010c 00003033 00000001 ffffffff 00000000 00000000 00000001 00000000 00000000
01000000 00000110 00002013 fffffff0 00000001 00000000 00000000 00000001 00000000 00000000
01000000 00000114 00004013 0f0f0f0f ffffff00 00000000 00000000 f0f0f00f 00000000 00000000
01000000 00000118 00000037 00000000 12345000 00000000 00000000 12345000 00000000 00000000
01000000 0000011c 00000017 0000011c 00001000 00000000 00000000 0000111c 00000000 00000000
01000000 00000120 00000013 00000010 00000001 00000000 00000000 00000011 00000000 00000000
01000010 00000124 00000033 00000000 00000022 00000000 00000000 00000033 00000000 00000000
01000030 00000128 00000033 00000000 00000000 00000000 00000000 00000066 00000000 00000000
21000010 0000012c 00001033 00000000 00000004 00000000 00000000 00000660 00000000 00000000
02100000 00000130 00000063 00000005 00000005 00000040 00000000 00000000 00000170 00000000
00000100 00000134 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
02000000 00000138 00004063 00000005 fffffffb 00000010 00000000 00000000 00000148 00000000
02100000 0000013c 00007063 ffffffff 00000001 fffffff0 00000000 00000000 0000012c 00000000
00000100 00000140 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
03100000 00000144 0000006f 00000000 00000000 00000100 00000000 00000148 00000244 00000000
00000100 00000148 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
03100000 0000014c 00000067 00001001 00000000 00000006 00000000 00000150 00001006 00000000
00000100 00000150 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
04012000 00000154 00002023 00002000 deadbeef 00000010 deadbeef 00000000 00000000 00002010
04010000 00000158 00000023 00002003 000000a5 00000000 a5a5a5a5 00000000 00000000 00002003
05000000 0000015c 00000003 00002000 00000000 00000001 11228344 ffffff83 00000000 00002001
05001000 00000160 00005003 00002000 00000000 00000002 9abc1234 00009abc 00000000 00002002
15002010 00000164 00002003 00000000 00000000 00000004 0badf00d 0badf00d 00000000 00009ac0
05001000 00000168 00001003 00002000 00000000 00000002 80001234 ffff8000 00000000 00002002
01000010 0000016c 00000033 00000000 00000001 00000000 00000000 ffff8001 00000000 00000000

// File: dv/tb_ex_stage.sv
// Execute stage testbench
// Replays golden vectors, answers memory requests and checks results

`timescale 1ns/10ps
`include "ex_defs.svh"

module tb_ex_stage;
  import ex_pkg::*;

  localparam int NUM_VEC     = 28;
  localparam int WORDS       = 10;
  localparam int CYCLE_LIMIT = NUM_VEC * 6 + 20;

  logic      clk_i;
  logic      rst_ni;
  xlen_t     id_pc_i;
  instr_t    id_insn_i;
  logic      id_bubble_i;
  logic      id_bypex_opa_i;
  logic      id_bypex_opb_i;
  logic      id_userf_opa_i;
  logic      id_userf_opb_i;
  xlen_t     id_opa_i;
  xlen_t     id_opb_i;
  xlen_t     id_imm_i;
  xlen_t     rf_srcv1_i;
  xlen_t     rf_srcv2_i;
  logic      mem_stall_i;
  logic      ex_stall_o;
  xlen_t     ex_pc_o;
  instr_t    ex_insn_o;
  xlen_t     ex_r_o;
  logic      ex_bubble_o;
  xlen_t     bu_nxt_pc_o;
  logic      bu_flush_o;
  logic      dmem_req_o;
  xlen_t     dmem_adr_o;
  mem_size_t dmem_size_o;
  logic      dmem_we_o;
  xlen_t     dmem_d_o;
  xlen_t     dmem_q_i;
  logic      dmem_ack_i;

  // Ten words per vector: ctrl pc insn opa opb imm mdata exp_r exp_npc exp_adr
  logic [31:0] gold [NUM_VEC*WORDS];
  integer      seed;
  int          cycles;

  ex_stage ex_stage_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT)
    begin
      $display("Run stopped: the cycle limit was reached before all vectors finished");
      $display("Done: errors found");
      $fatal(1);
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("error: %s got %h expected %h", name, got, exp);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////
  // One golden vector
  ////////////////////////////////////////

  task automatic run_vector(input int v);
    logic [31:0] ctrl;
    logic [31:0] opa;
    logic [31:0] opb;
    logic [31:0] mdata;
    xlen_t       held_pc;
    xlen_t       held_r;
    int          delay;
    ctrl  = gold[v*WORDS];
    opa   = gold[v*WORDS+3];
    opb   = gold[v*WORDS+4];
    mdata = gold[v*WORDS+6];

    // An access still in flight keeps the ID side waiting
    while (ex_stall_o)
    begin
      @(posedge clk_i);
      #1;
    end

    id_pc_i        = gold[v*WORDS+1];
    id_insn_i      = gold[v*WORDS+2];
    id_imm_i       = gold[v*WORDS+5];
    id_bubble_i    = ctrl[8];
    id_bypex_opa_i = ctrl[4];
    id_bypex_opb_i = ctrl[5];
    id_userf_opa_i = ctrl[0];
    id_userf_opb_i = ctrl[1];
    // Unused source gets the inverted value so a wrong pick shows
    id_opa_i       = ctrl[0] ? ~opa : opa;
    rf_srcv1_i     = ctrl[0] ? opa : ~opa;
    id_opb_i       = ctrl[1] ? ~opb : opb;
    rf_srcv2_i     = ctrl[1] ? opb : ~opb;

    // MEM back-pressure before the instruction may enter
    mem_stall_i = (ctrl[31:28] != 4'd0);
    held_pc     = ex_pc_o;
    held_r      = ex_r_o;
    repeat (ctrl[31:28])
    begin
      @(posedge clk_i);
      #1;
      check_value("ex_stall_o", ex_stall_o, 1);
      check_value("ex_pc_o", ex_pc_o, held_pc);
      check_value("ex_r_o", ex_r_o, held_r);
    end
    mem_stall_i = 1'b0;

    @(posedge clk_i);
    #1;
    check_value("ex_pc_o", ex_pc_o, gold[v*WORDS+1]);
    check_value("ex_insn_o", ex_insn_o, gold[v*WORDS+2]);

    if (ctrl[26])
    begin
      check_value("dmem_req_o", dmem_req_o, 1);
      check_value("ex_stall_o", ex_stall_o, 1);
      check_value("dmem_adr_o", dmem_adr_o, gold[v*WORDS+9]);
      check_value("dmem_size_o", dmem_size_o, ctrl[13:12]);
      check_value("dmem_we_o", dmem_we_o, ctrl[16]);
      if (ctrl[16])
        check_value("dmem_d_o", dmem_d_o, mdata);
      delay = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
      repeat (delay - 1)
      begin
        @(posedge clk_i);
        #1;
        check_value("dmem_req_o", dmem_req_o, 1);
        check_value("ex_stall_o", ex_stall_o, 1);
      end
      dmem_q_i   = mdata;
      dmem_ack_i = 1'b1;
      @(posedge clk_i);
      #1;
      dmem_ack_i = 1'b0;
      check_value("dmem_req_o", dmem_req_o, 0);
      check_value("ex_stall_o", ex_stall_o, 0);
    end

    check_value("bu_flush_o", bu_flush_o, ctrl[20]);
    // A result is present exactly when one is expected
    check_value("ex_bubble_o", ex_bubble_o, !ctrl[24]);
    if (ctrl[24])
      check_value("ex_r_o", ex_r_o, gold[v*WORDS+7]);
    if (ctrl[25])
      check_value("bu_nxt_pc_o", bu_nxt_pc_o, gold[v*WORDS+8]);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial
  begin
    cycles         = 0;
    seed           = 32'h5ec52091;
    rst_ni         = 1'b0;
    id_pc_i        = '0;
    id_insn_i      = '0;
    id_bubble_i    = 1'b1;
    id_bypex_opa_i = 1'b0;
    id_bypex_opb_i = 1'b0;
    id_userf_opa_i = 1'b0;
    id_userf_opb_i = 1'b0;
    id_opa_i       = '0;
    id_opb_i       = '0;
    id_imm_i       = '0;
    rf_srcv1_i     = '0;
    rf_srcv2_i     = '0;
    mem_stall_i    = 1'b0;
    dmem_q_i       = '0;
    dmem_ack_i     = 1'b0;
    $readmemh("dv/ex_golden.hex", gold);

    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_value("ex_pc_o", ex_pc_o, `EX_PC_INIT);
    check_value("ex_bubble_o", ex_bubble_o, 1);
    check_value("dmem_req_o", dmem_req_o, 0);
    check_value("bu_flush_o", bu_flush_o, 0);

    for (int v = 0; v < NUM_VEC; v++)
      run_vector(v);

    if (ex_stage_i.ex_stage_asserts_i.fail_cnt == 0)
    begin
      $display("Done: no errors");
      $finish;
    end
    else
    begin
      $display("Done: errors found");
      $fatal(1);
    end
  end

endmodule

// File: dv/ex_stage_asserts.sv
// Execute stage checks
// Memory request stability, flush source, PC hold and reset behavior

`timescale 1ns/10ps
`include "ex_defs.svh"

module ex_stage_asserts
(
  input logic              clk_i,
  input logic              rst_ni,
  input logic              dmem_req_o,
  input logic              dmem_ack_i,
  input ex_pkg::xlen_t     dmem_adr_o,
  input ex_pkg::mem_size_t dmem_size_o,
  input logic              ex_stall_o,
  input logic              bu_flush_o,
  input ex_pkg::xlen_t     ex_pc_o,
  input ex_pkg::instr_t    ex_insn_o
);

  // Number of failed properties
  int unsigned fail_cnt = 0;

  // Request and its fields stay put until the ack
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dmem_req_o && !dmem_ack_i |=> dmem_req_o && $stable(dmem_adr_o) && $stable(dmem_size_o))
  else
  begin
    fail_cnt++;
    $error("memory request dropped or changed before ack");
  end

  // Flush only comes from a branch or jump in EX
  flush_src: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bu_flush_o |-> ex_insn_o[6:0] inside {`OPC_BRANCH, `OPC_JAL, `OPC_JALR})
  else
  begin
    fail_cnt++;
    $error("flush without a control transfer in EX");
  end

  pc_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ex_stall_o |=> $stable(ex_pc_o))
  else
  begin
    fail_cnt++;
    $error("EX PC moved during a stall");
  end

  no_req_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !dmem_req_o)
  else
  begin
    fail_cnt++;
    $error("memory request during reset");
  end

endmodule

bind ex_stage ex_stage_asserts ex_stage_asserts_i (.*);

// File: rtl/ex_stage.sv
// RV32I execute stage top
// Connects the bypass block with the ALU, branch unit and load-store unit

`timescale 1ns/10ps

module ex_stage
(
  input  logic              clk_i,
  input  logic              rst_ni,

  input  ex_pkg::xlen_t     id_pc_i,
  input  ex_pkg::instr_t    id_insn_i,
  input  logic              id_bubble_i,
  input  logic              id_bypex_opa_i,
  input  logic              id_bypex_opb_i,
  input  logic              id_userf_opa_i,
  input  logic              id_userf_opb_i,
  input  ex_pkg::xlen_t     id_opa_i,
  input  ex_pkg::xlen_t     id_opb_i,
  input  ex_pkg::xlen_t     id_imm_i,

  input  ex_pkg::xlen_t     rf_srcv1_i,
  input  ex_pkg::xlen_t     rf_srcv2_i,

  input  logic              mem_stall_i,
  output logic              ex_stall_o,

  output ex_pkg::xlen_t     ex_pc_o,
  output ex_pkg::instr_t    ex_insn_o,
  output ex_pkg::xlen_t     ex_r_o,
  output logic              ex_bubble_o,

  output ex_pkg::xlen_t     bu_nxt_pc_o,
  output logic              bu_flush_o,

  output logic              dmem_req_o,
  output ex_pkg::xlen_t     dmem_adr_o,
  output ex_pkg::mem_size_t dmem_size_o,
  output logic              dmem_we_o,
  output ex_pkg::xlen_t     dmem_d_o,
  input  ex_pkg::xlen_t     dmem_q_i,
  input  logic              dmem_ack_i
);
  import ex_pkg::*;

  logic  stall;
  logic  lsu_stall;
  xlen_t alu_r;
  xlen_t bu_r;
  xlen_t lsu_r;
  logic  alu_bubble;
  logic  bu_bubble;
  logic  lsu_bubble;

  ex_operand_if op_if ();

  ////////////////////////////////////////
  // Input side
  ////////////////////////////////////////

  ex_bypass ex_bypass_i
  (
    .op_o         (op_if.src),
    .stall_o      (stall),
    .lsu_stall_i  (lsu_stall),
    .alu_r_i      (alu_r),
    .bu_r_i       (bu_r),
    .lsu_r_i      (lsu_r),
    .alu_bubble_i (alu_bubble),
    .bu_bubble_i  (bu_bubble),
    .lsu_bubble_i (lsu_bubble),
    .*
  );

  ////////////////////////////////////////
  // Execution units
  ////////////////////////////////////////

  ex_alu ex_alu_i
  (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .op_i         (op_if.unit),
    .stall_i      (stall),
    .alu_r_o      (alu_r),
    .alu_bubble_o (alu_bubble)
  );

  // Compare sources are the bypassed operands
  ex_branch_unit ex_branch_unit_i
  (
    .op_i         (op_if.unit),
    .rs1_i        (op_if.opa),
    .rs2_i        (op_if.opb),
    .imm_i        (id_imm_i),
    .stall_i      (stall),
    .bu_r_o       (bu_r),
    .bu_bubble_o  (bu_bubble),
    .*
  );

  ex_lsu ex_lsu_i
  (
    .op_i         (op_if.unit),
    .imm_i        (id_imm_i),
    .lsu_stall_o  (lsu_stall),
    .lsu_r_o      (lsu_r),
    .lsu_bubble_o (lsu_bubble),
    .*
  );

endmodule

// File: rtl/ex_lsu.sv
// Load-store unit
// Sequences data-memory requests, aligns and extends load data

`timescale 1ns/10ps
`include "ex_defs.svh"

module ex_lsu
(
  input  logic              clk_i,
  input  logic              rst_ni,

  ex_operand_if.unit        op_i,
  input  ex_pkg::xlen_t     imm_i,
  input  logic              mem_stall_i,

  output logic              lsu_stall_o,
  output ex_pkg::xlen_t     lsu_r_o,
  output logic              lsu_bubble_o,

  output logic              dmem_req_o,
  output ex_pkg::xlen_t     dmem_adr_o,
  output ex_pkg::mem_size_t dmem_size_o,
  output logic              dmem_we_o,
  output ex_pkg::xlen_t     dmem_d_o,
  input  ex_pkg::xlen_t     dmem_q_i,
  input  logic              dmem_ack_i
);
  import ex_pkg::*;

  lsu_state_t state;
  opcode_t    opcode;
  funct3_t    funct3;
  funct3_t    ld_f3;
  logic       is_load;
  logic       is_store;
  logic       accept;
  mem_size_t  size;
  xlen_t      wdata;
  xlen_t      lane;
  xlen_t      load_val;

  assign opcode   = op_i.insn[6:0];
  assign funct3   = op_i.insn[14:12];
  assign is_load  = ~op_i.bubble & (opcode == `OPC_LOAD);
  assign is_store = ~op_i.bubble & (opcode == `OPC_STORE);

  // Stage only moves when idle and not held by MEM
  assign accept      = (state == LSU_IDLE) & ~mem_stall_i & (is_load | is_store);
  assign lsu_stall_o = (state == LSU_WAIT);

  // Size code and store data replicated over the lanes
  always_comb
  begin
    case (funct3[1:0])
      2'b00:
      begin
        size  = `MEM_SIZE_BYTE;
        wdata = {4{op_i.opb[7:0]}};
      end
      2'b01:
      begin
        size  = `MEM_SIZE_HALF;
        wdata = {2{op_i.opb[15:0]}};
      end
      default:
      begin
        size  = `MEM_SIZE_WORD;
        wdata = op_i.opb;
      end
    endcase
  end

  ////////////////////////////////////////
  // Load alignment
  ////////////////////////////////////////

  assign lane = dmem_q_i >> {dmem_adr_o[1:0], 3'b000};

  always_comb
  begin
    case (ld_f3)
      `F3_LB:  load_val = {{(`EX_XLEN-8){lane[7]}}, lane[7:0]};
      `F3_LH:  load_val = {{(`EX_XLEN-16){lane[15]}}, lane[15:0]};
      `F3_LBU: load_val = {{(`EX_XLEN-8){1'b0}}, lane[7:0]};
      `F3_LHU: load_val = {{(`EX_XLEN-16){1'b0}}, lane[15:0]};
      default: load_val = lane;
    endcase
  end

  ////////////////////////////////////////
  // Request FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state        <= LSU_IDLE;
      dmem_req_o   <= 1'b0;
      dmem_we_o    <= 1'b0;
      lsu_bubble_o <= 1'b1;
    end
    else
    begin
      case (state)
        LSU_IDLE:
        begin
          if (!mem_stall_i)
            lsu_bubble_o <= 1'b1;
          if (accept)
          begin
            state      <= LSU_WAIT;
            dmem_req_o <= 1'b1;
            dmem_we_o  <= is_store;
          end
        end
        default:
        begin
          if (dmem_ack_i)
          begin
            state        <= LSU_IDLE;
            dmem_req_o   <= 1'b0;
            dmem_we_o    <= 1'b0;
            // Result only for loads
            lsu_bubble_o <= dmem_we_o;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      dmem_adr_o  <= op_i.opa + imm_i;
      dmem_size_o <= size;
      dmem_d_o    <= wdata;
      ld_f3       <= funct3;
    end
    if (state == LSU_WAIT && dmem_ack_i && !dmem_we_o)
      lsu_r_o <= load_val;
  end

endmodule

// File: rtl/ex_branch_unit.sv
// Branch unit
// Resolves branches and jumps, produces next PC, link value and flush pulse

`timescale 1ns/10ps
`include "ex_defs.svh"

module ex_branch_unit
(
  input  logic          clk_i,
  input  logic          rst_ni,

  ex_operand_if.unit    op_i,
  input  ex_pkg::xlen_t rs1_i,
  input  ex_pkg::xlen_t rs2_i,
  input  ex_pkg::xlen_t imm_i,
  input  logic          stall_i,

  output ex_pkg::xlen_t bu_nxt_pc_o,
  output ex_pkg::xlen_t bu_r_o,
  output logic          bu_flush_o,
  output logic          bu_bubble_o
);
  import ex_pkg::*;

  opcode_t opcode;
  funct3_t funct3;
  logic    is_branch;
  logic    is_jal;
  logic    is_jalr;
  logic    is_jump;
  logic    cond;
  logic    taken;
  xlen_t   jalr_tgt;
  xlen_t   nxt_pc;

  assign opcode    = op_i.insn[6:0];
  assign funct3    = op_i.insn[14:12];
  assign is_branch = ~op_i.bubble & (opcode == `OPC_BRANCH);
  assign is_jal    = ~op_i.bubble & (opcode == `OPC_JAL);
  assign is_jalr   = ~op_i.bubble & (opcode == `OPC_JALR);
  assign is_jump   = is_jal | is_jalr;

  always_comb
  begin
    case (funct3)
      `F3_BEQ:  cond = rs1_i == rs2_i;
      `F3_BNE:  cond = rs1_i != rs2_i;
      `F3_BLT:  cond = $signed(rs1_i) < $signed(rs2_i);
      `F3_BGE:  cond = $signed(rs1_i) >= $signed(rs2_i);
      `F3_BLTU: cond = rs1_i < rs2_i;
      `F3_BGEU: cond = rs1_i >= rs2_i;
      default:  cond = 1'b0;
    endcase
  end

  assign taken = (is_branch & cond) | is_jump;

  // JALR target has bit 0 forced low
  assign jalr_tgt = rs1_i + imm_i;

  always_comb
  begin
    if (is_jalr)
      nxt_pc = {jalr_tgt[`EX_XLEN-1:1], 1'b0};
    else if (is_branch || is_jal)
      nxt_pc = op_i.pc + imm_i;
    else
      nxt_pc = op_i.pc + `EX_XLEN'd4;
  end

  ////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      bu_flush_o  <= 1'b0;
      bu_bubble_o <= 1'b1;
    end
    else if (!stall_i)
    begin
      bu_flush_o  <= taken;
      bu_bubble_o <= ~is_jump;
    end
    else
      // Single pulse, never stretched by a stall
      bu_flush_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      bu_nxt_pc_o <= nxt_pc;
      bu_r_o      <= op_i.pc + `EX_XLEN'd4;
    end
  end

endmodule

// File: rtl/ex_alu.sv
// Integer ALU
// Registered RV32I OP, OP-IMM, LUI and AUIPC results

`timescale 1ns/10ps
`include "ex_defs.svh"

module ex_alu
(
  input  logic          clk_i,
  input  logic          rst_ni,

  ex_operand_if.unit    op_i,
  input  logic          stall_i,

  output ex_pkg::xlen_t alu_r_o,
  output logic          alu_bubble_o
);
  import ex_pkg::*;

  opcode_t    opcode;
  funct3_t    funct3;
  logic       alt;
  logic [4:0] shamt;
  logic       is_alu;
  xlen_t      res;

  assign opcode = op_i.insn[6:0];
  assign funct3 = op_i.insn[14:12];
  // funct7 bit 5 picks SUB and SRA
  assign alt    = op_i.insn[30];
  assign shamt  = op_i.opb[4:0];

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////

  always_comb
  begin
    is_alu = 1'b1;
    res    = op_i.opa + op_i.opb;
    case (opcode)
      // Decode already prepared the upper immediate and the PC
      `OPC_LUI,
      `OPC_AUIPC:
        res = op_i.opa + op_i.opb;
      `OPC_OP,
      `OPC_OP_IMM:
        case (funct3)
          `F3_ADD:
          begin
            if (alt && opcode == `OPC_OP)
              res = op_i.opa - op_i.opb;
            else
              res = op_i.opa + op_i.opb;
          end
          `F3_SLL:  res = op_i.opa << shamt;
          `F3_SLT:  res = {{(`EX_XLEN-1){1'b0}}, $signed(op_i.opa) < $signed(op_i.opb)};
          `F3_SLTU: res = {{(`EX_XLEN-1){1'b0}}, op_i.opa < op_i.opb};
          `F3_XOR:  res = op_i.opa ^ op_i.opb;
          `F3_SR:
          begin
            if (alt)
              res = $signed(op_i.opa) >>> shamt;
            else
              res = op_i.opa >> shamt;
          end
          `F3_OR:   res = op_i.opa | op_i.opb;
          default:  res = op_i.opa & op_i.opb;
        endcase
      default:
        is_alu = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      alu_bubble_o <= 1'b1;
    else if (!stall_i)
      alu_bubble_o <= op_i.bubble | ~is_alu;
  end

  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
      alu_r_o <= res;
  end

endmodule

// File: rtl/ex_bypass.sv
// EX input side
// ID/EX registers, operand bypass, unit result merge and stall combine

`timescale 1ns/10ps
`include "ex_defs.svh"

module ex_bypass
(
  input  logic           clk_i,
  input  logic           rst_ni,

  input  ex_pkg::xlen_t  id_pc_i,
  input  ex_pkg::instr_t id_insn_i,
  input  logic           id_bubble_i,

  input  logic           id_bypex_opa_i,
  input  logic           id_bypex_opb_i,
  input  logic           id_userf_opa_i,
  input  logic           id_userf_opb_i,
  input  ex_pkg::xlen_t  id_opa_i,
  input  ex_pkg::xlen_t  id_opb_i,
  input  ex_pkg::xlen_t  rf_srcv1_i,
  input  ex_pkg::xlen_t  rf_srcv2_i,

  input  logic           mem_stall_i,
  input  logic           lsu_stall_i,

  input  ex_pkg::xlen_t  alu_r_i,
  input  ex_pkg::xlen_t  bu_r_i,
  input  ex_pkg::xlen_t  lsu_r_i,
  input  logic           alu_bubble_i,
  input  logic           bu_bubble_i,
  input  logic           lsu_bubble_i,

  ex_operand_if.src      op_o,

  output logic           stall_o,
  output logic           ex_stall_o,
  output ex_pkg::xlen_t  ex_pc_o,
  output ex_pkg::instr_t ex_insn_o,
  output ex_pkg::xlen_t  ex_r_o,
  output logic           ex_bubble_o
);
  import ex_pkg::*;

  // EX result first, then register file, then decode operand
  function automatic xlen_t sel_operand(input logic  userf,
                                        input logic  bypex,
                                        input xlen_t rf_val,
                                        input xlen_t id_val,
                                        input xlen_t ex_val);
    if (bypex)
      return ex_val;
    else if (userf)
      return rf_val;
    else
      return id_val;
  endfunction

  ////////////////////////////////////////
  // Operands towards the units
  ////////////////////////////////////////

  assign op_o.pc     = id_pc_i;
  assign op_o.insn   = id_insn_i;
  assign op_o.bubble = id_bubble_i;
  assign op_o.opa    = sel_operand(id_userf_opa_i, id_bypex_opa_i, rf_srcv1_i, id_opa_i, ex_r_o);
  assign op_o.opb    = sel_operand(id_userf_opb_i, id_bypex_opb_i, rf_srcv2_i, id_opb_i, ex_r_o);

  // Any stall source freezes the whole stage
  assign stall_o    = mem_stall_i | lsu_stall_i;
  assign ex_stall_o = stall_o;

  ////////////////////////////////////////
  // ID/EX registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      ex_pc_o <= `EX_PC_INIT;
    else if (!ex_stall_o)
      ex_pc_o <= id_pc_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (!ex_stall_o)
      ex_insn_o <= id_insn_i;
  end

  // Load data wins over the link value, ALU result otherwise
  always_comb
  begin
    if (!lsu_bubble_i)
      ex_r_o = lsu_r_i;
    else if (!bu_bubble_i)
      ex_r_o = bu_r_i;
    else
      ex_r_o = alu_r_i;
  end

  assign ex_bubble_o = alu_bubble_i & bu_bubble_i & lsu_bubble_i;

endmodule

// File: rtl/ex_operand_if.sv
// Issued instruction bundle
// PC, instruction word, selected operands and bubble flag towards the units

`timescale 1ns/10ps

interface ex_operand_if;
  import ex_pkg::*;

  xlen_t  pc;
  instr_t insn;
  xlen_t  opa;
  xlen_t  opb;
  logic   bubble;

  // Driven by the bypass block
  modport src
  (
    output pc, insn, opa, opb, bubble
  );

  // Read by the ALU, branch unit and LSU
  modport unit
  (
    input pc, insn, opa, opb, bubble
  );

endinterface

// File: rtl/ex_pkg.sv
// Execute stage types
// Word, instruction and field vectors plus the LSU state encoding

`include "ex_defs.svh"

package ex_pkg;

  // Data or address word
  typedef logic [`EX_XLEN-1:0] xlen_t;

  // Raw instruction word
  typedef logic [31:0] instr_t;

  // Instruction fields
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;

  // Holds one of the MEM_SIZE codes
  typedef logic [1:0] mem_size_t;

  // Data-memory request sequencing
  typedef enum logic
  {
    LSU_IDLE,
    LSU_WAIT
  } lsu_state_t;

endpackage

// File: include/ex_defs.svh
// Execute stage constants
// Data width, reset PC, RV32I opcode and funct3 codes, memory size codes

`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

`define EX_XLEN       32
`define EX_PC_INIT    32'h0000_0200

// Major opcodes
`define OPC_OP        7'b0110011
`define OPC_OP_IMM    7'b0010011
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111
`define OPC_BRANCH    7'b1100011
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_LOAD      7'b0000011
`define OPC_STORE     7'b0100011

// ALU funct3
`define F3_ADD        3'b000
`define F3_SLL        3'b001
`define F3_SLT        3'b010
`define F3_SLTU       3'b011
`define F3_XOR        3'b100
`define F3_SR         3'b101
`define F3_OR         3'b110
`define F3_AND        3'b111

// Branch conditions
`define F3_BEQ        3'b000
`define F3_BNE        3'b001
`define F3_BLT        3'b100
`define F3_BGE        3'b101
`define F3_BLTU       3'b110
`define F3_BGEU       3'b111

// Load widths, stores share the low two bits
`define F3_LB         3'b000
`define F3_LH         3'b001
`define F3_LW         3'b010
`define F3_LBU        3'b100
`define F3_LHU        3'b101

`define MEM_SIZE_BYTE 2'b00
`define MEM_SIZE_HALF 2'b01
`define MEM_SIZE_WORD 2'b10

`endif
